//--- logic/mondo_pkg.sv
package mondo_pkg;

   // Width of a mondo data word and of register data
   localparam int DATA_WIDTH = 64;

   // Local register address width
   localparam int ADDR_WIDTH = 16;

   // Proper addresses, used by the debug port
   // Thread index field starts at bit 3
   localparam logic [ADDR_WIDTH-1:0] CREG_MDATA0 = 16'h0000;
   localparam logic [ADDR_WIDTH-1:0] CREG_MDATA1 = 16'h1000;
   localparam logic [ADDR_WIDTH-1:0] CREG_MBUSY  = 16'h2000;

   // Alias addresses, entry picked by the requesting thread id
   localparam logic [ADDR_WIDTH-1:0] CREG_MDATA0_ALIAS = 16'h4000;
   localparam logic [ADDR_WIDTH-1:0] CREG_MDATA1_ALIAS = 16'h4008;
   localparam logic [ADDR_WIDTH-1:0] CREG_MBUSY_ALIAS  = 16'h4010;

   // Widest thread index the map allows, bits 3 to 11
   localparam int MAX_THR_INDEX = 9;

   // Lowest bit of the thread index field
   localparam int THR_ADDR_LSB = 3;

   // Ones over the whole index field, then shifted into place
   localparam logic [ADDR_WIDTH-1:0] THR_FIELD_ONES = {MAX_THR_INDEX{1'b1}};
   // Clears the index field before a proper address compare
   localparam logic [ADDR_WIDTH-1:0] THR_ADDR_MASK = ~(THR_FIELD_ONES << THR_ADDR_LSB);

   // Register select code shared by decoder, access engine and table
   typedef enum logic [1:0] {
      SEL_MDATA0 = 2'd0,
      SEL_MDATA1 = 2'd1,
      SEL_MBUSY  = 2'd2
   } reg_sel_e;

   // Response status codes
   localparam logic RSP_OK  = 1'b0;
   localparam logic RSP_ERR = 1'b1;

endpackage

//--- logic/mondo_addr_dec.sv
`timescale 1ns/10ps

module mondo_addr_dec #(
   parameter int NUM_THREADS = 32,
   localparam int THR_W = $clog2(NUM_THREADS)
) (
   input  logic [mondo_pkg::ADDR_WIDTH-1:0] addr,
   input  logic [THR_W-1:0]                 thr,
   output mondo_pkg::reg_sel_e              sel,
   output logic [THR_W-1:0]                 idx,
   output logic                             addr_invld
);

   import mondo_pkg::*;

   // Alias hits, exact compare
   logic mdata0_alias_dec;
   logic mdata1_alias_dec;
   logic mbusy_alias_dec;
   // Proper hits, compare with index field masked off
   logic mdata0_proper_dec;
   logic mdata1_proper_dec;
   logic mbusy_proper_dec;
   // Per-register decode, either form
   logic mdata0_dec;
   logic mdata1_dec;
   logic mbusy_dec;
   logic use_thr;
   logic [ADDR_WIDTH-1:0] addr_masked;

   // Software path, own entry through the alias page
   assign mdata0_alias_dec = (addr == CREG_MDATA0_ALIAS);
   assign mdata1_alias_dec = (addr == CREG_MDATA1_ALIAS);
   assign mbusy_alias_dec  = (addr == CREG_MBUSY_ALIAS);

   // Debug path, thread index carried in the address
   assign addr_masked       = addr & THR_ADDR_MASK;
   assign mdata0_proper_dec = (addr_masked == CREG_MDATA0);
   assign mdata1_proper_dec = (addr_masked == CREG_MDATA1);
   assign mbusy_proper_dec  = (addr_masked == CREG_MBUSY);

   assign mdata0_dec = mdata0_alias_dec | mdata0_proper_dec;
   assign mdata1_dec = mdata1_alias_dec | mdata1_proper_dec;
   assign mbusy_dec  = mbusy_alias_dec | mbusy_proper_dec;

   // Alias hit means the requester's own thread id is the index
   assign use_thr = mdata0_alias_dec | mdata1_alias_dec | mbusy_alias_dec;
   assign idx     = use_thr ? thr : addr[THR_ADDR_LSB +: THR_W];

   // Decodes are exclusive, so priority order does not matter
   always_comb begin
      if (mbusy_dec) begin
         sel = SEL_MBUSY;
      end else if (mdata1_dec) begin
         sel = SEL_MDATA1;
      end else begin
         sel = SEL_MDATA0;
      end
   end

   // Nothing matched
   assign addr_invld = ~mdata0_dec & ~mdata1_dec & ~mbusy_dec;

endmodule

//--- logic/mondo_data_table.sv
`timescale 1ns/10ps

module mondo_data_table #(
   parameter int NUM_THREADS = 32,
   localparam int THR_W = $clog2(NUM_THREADS)
) (
   input  logic                             clk,
   input  logic                             reset,
   // Register write port
   input  logic                             csr_wr_en,
   input  mondo_pkg::reg_sel_e              csr_sel,
   input  logic [THR_W-1:0]                 csr_idx,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] csr_wdata,
   // Register read port
   input  logic [THR_W-1:0]                 csr_rd_idx,
   output logic [mondo_pkg::DATA_WIDTH-1:0] rd_data0,
   output logic [mondo_pkg::DATA_WIDTH-1:0] rd_data1,
   output logic                             rd_busy,
   // Mondo insert port
   input  logic                             ins_req,
   input  logic [THR_W-1:0]                 ins_thr,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] ins_data0,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] ins_data1,
   output logic                             ins_gnt,
   output logic                             ins_nack
);

   import mondo_pkg::*;

   // Per-thread data words, no reset
   logic [DATA_WIDTH-1:0] data0_mem [NUM_THREADS];
   logic [DATA_WIDTH-1:0] data1_mem [NUM_THREADS];
   // One busy flag per thread
   logic [NUM_THREADS-1:0] busy;

   logic csr_wr_data0;
   logic csr_wr_data1;
   logic csr_wr_busy;
   logic ins_write;

   // Register writes win, insert waits a cycle
   assign ins_gnt  = ins_req & ~csr_wr_en;
   // Target already holds an unserviced mondo
   assign ins_nack = ins_req & busy[ins_thr];
   // Insert lands only when granted and the entry is free
   assign ins_write = ins_gnt & ~ins_nack;

   assign csr_wr_data0 = csr_wr_en & (csr_sel == SEL_MDATA0);
   assign csr_wr_data1 = csr_wr_en & (csr_sel == SEL_MDATA1);
   assign csr_wr_busy  = csr_wr_en & (csr_sel == SEL_MBUSY);

   // Read port is purely combinational
   assign rd_data0 = data0_mem[csr_rd_idx];
   assign rd_data1 = data1_mem[csr_rd_idx];
   assign rd_busy  = busy[csr_rd_idx];

   // Data words, one writer per cycle at most
   always_ff @(posedge clk) begin
      if (csr_wr_data0) begin
         data0_mem[csr_idx] <= csr_wdata;
      end else if (ins_write) begin
         data0_mem[ins_thr] <= ins_data0;
      end
      if (csr_wr_data1) begin
         data1_mem[csr_idx] <= csr_wdata;
      end else if (ins_write) begin
         data1_mem[ins_thr] <= ins_data1;
      end
   end

   // Busy flags
   // Software sets or clears from bit 0, insert only sets
   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= '0;
      end else if (csr_wr_busy) begin
         busy[csr_idx] <= csr_wdata[0];
      end else if (ins_write) begin
         busy[ins_thr] <= 1'b1;
      end
   end

endmodule

//--- logic/mondo_intake.sv
`timescale 1ns/10ps

module mondo_intake #(
   parameter int NUM_THREADS = 32,
   localparam int THR_W = $clog2(NUM_THREADS)
) (
   input  logic                             clk,
   input  logic                             reset,
   // Incoming mondo
   input  logic                             mondo_valid,
   output logic                             mondo_ready,
   input  logic [THR_W-1:0]                 mondo_thr,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] mondo_data0,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] mondo_data1,
   // Insert request to the table
   output logic                             ins_req,
   output logic [THR_W-1:0]                 ins_thr,
   output logic [mondo_pkg::DATA_WIDTH-1:0] ins_data0,
   output logic [mondo_pkg::DATA_WIDTH-1:0] ins_data1,
   input  logic                             ins_gnt,
   input  logic                             ins_nack,
   // Ack back to the sender
   output logic                             ack_valid,
   output logic                             ack_nack
);

   import mondo_pkg::*;

   // Stage occupancy
   logic full;
   logic accept;
   // Held mondo
   logic [THR_W-1:0]      thr_q;
   logic [DATA_WIDTH-1:0] data0_q;
   logic [DATA_WIDTH-1:0] data1_q;

   // Single entry, no new mondo until the held one is granted
   assign mondo_ready = ~full;
   assign accept      = mondo_valid & mondo_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         full <= 1'b0;
      end else if (accept) begin
         full <= 1'b1;
      end else if (ins_gnt) begin
         full <= 1'b0;
      end
   end

   // Payload capture
   always_ff @(posedge clk) begin
      if (accept) begin
         thr_q   <= mondo_thr;
         data0_q <= mondo_data0;
         data1_q <= mondo_data1;
      end
   end

   assign ins_req   = full;
   assign ins_thr   = thr_q;
   assign ins_data0 = data0_q;
   assign ins_data1 = data1_q;

   // One-cycle ack pulse after the grant
   always_ff @(posedge clk) begin
      if (reset) begin
         ack_valid <= 1'b0;
      end else begin
         ack_valid <= ins_gnt;
      end
   end

   // Nack status as seen by the table at grant time
   always_ff @(posedge clk) begin
      if (ins_gnt) begin
         ack_nack <= ins_nack;
      end
   end

endmodule

//--- logic/mondo_creg_access.sv
`timescale 1ns/10ps

module mondo_creg_access #(
   parameter int NUM_THREADS = 32,
   localparam int THR_W = $clog2(NUM_THREADS)
) (
   input  logic                             clk,
   input  logic                             reset,
   // Register request
   input  logic                             req_valid,
   output logic                             req_ready,
   input  logic                             req_write,
   input  logic [mondo_pkg::ADDR_WIDTH-1:0] req_addr,
   input  logic [THR_W-1:0]                 req_thr,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] req_wdata,
   // Register response
   output logic                             rsp_valid,
   input  logic                             rsp_ready,
   output logic [mondo_pkg::DATA_WIDTH-1:0] rsp_data,
   output logic                             rsp_err,
   // Table write port
   output logic                             csr_wr_en,
   output mondo_pkg::reg_sel_e              csr_sel,
   output logic [THR_W-1:0]                 csr_idx,
   output logic [mondo_pkg::DATA_WIDTH-1:0] csr_wdata,
   // Table read port
   output logic [THR_W-1:0]                 csr_rd_idx,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] rd_data0,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] rd_data1,
   input  logic                             rd_busy
);

   import mondo_pkg::*;

   // Decoder results for the current request
   reg_sel_e         dec_sel;
   logic [THR_W-1:0] dec_idx;
   logic             dec_invld;

   logic                  accept;
   logic [DATA_WIDTH-1:0] rd_word;
   logic [DATA_WIDTH-1:0] rsp_data_nxt;

   mondo_addr_dec #(
      .NUM_THREADS (NUM_THREADS)
   ) mondo_addr_dec_i (
      .addr       (req_addr),
      .thr        (req_thr),
      .sel        (dec_sel),
      .idx        (dec_idx),
      .addr_invld (dec_invld)
   );

   // Slot free, or being drained this cycle
   assign req_ready = ~rsp_valid | rsp_ready;
   assign accept    = req_valid & req_ready;

   // Table write happens on the accepting edge
   assign csr_wr_en  = accept & req_write & ~dec_invld;
   assign csr_sel    = dec_sel;
   assign csr_idx    = dec_idx;
   assign csr_wdata  = req_wdata;
   assign csr_rd_idx = dec_idx;

   // Read data select, busy flag is zero extended
   always_comb begin
      case (dec_sel)
         SEL_MDATA0: rd_word = rd_data0;
         SEL_MDATA1: rd_word = rd_data1;
         SEL_MBUSY:  rd_word = {{(DATA_WIDTH-1){1'b0}}, rd_busy};
         default:    rd_word = '0;
      endcase
   end

   // Writes and bad addresses return zero data
   assign rsp_data_nxt = (req_write | dec_invld) ? '0 : rd_word;

   // Response slot occupancy
   always_ff @(posedge clk) begin
      if (reset) begin
         rsp_valid <= 1'b0;
      end else if (accept) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

   // Response payload, held until taken
   always_ff @(posedge clk) begin
      if (accept) begin
         rsp_data <= rsp_data_nxt;
         rsp_err  <= dec_invld ? RSP_ERR : RSP_OK;
      end
   end

endmodule

//--- logic/mondo_unit.sv
`timescale 1ns/10ps

module mondo_unit #(
   parameter int NUM_THREADS = 32,
   localparam int THR_W = $clog2(NUM_THREADS)
) (
   input  logic                             clk,
   input  logic                             reset,
   // Mondo intake
   input  logic                             mondo_valid,
   output logic                             mondo_ready,
   input  logic [THR_W-1:0]                 mondo_thr,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] mondo_data0,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] mondo_data1,
   output logic                             ack_valid,
   output logic                             ack_nack,
   // Control register request
   input  logic                             req_valid,
   output logic                             req_ready,
   input  logic                             req_write,
   input  logic [mondo_pkg::ADDR_WIDTH-1:0] req_addr,
   input  logic [THR_W-1:0]                 req_thr,
   input  logic [mondo_pkg::DATA_WIDTH-1:0] req_wdata,
   // Control register response
   output logic                             rsp_valid,
   input  logic                             rsp_ready,
   output logic [mondo_pkg::DATA_WIDTH-1:0] rsp_data,
   output logic                             rsp_err
);

   import mondo_pkg::*;

   // Register access to table
   logic                  csr_wr_en;
   reg_sel_e              csr_sel;
   logic [THR_W-1:0]      csr_idx;
   logic [DATA_WIDTH-1:0] csr_wdata;
   logic [THR_W-1:0]      csr_rd_idx;
   logic [DATA_WIDTH-1:0] rd_data0;
   logic [DATA_WIDTH-1:0] rd_data1;
   logic                  rd_busy;
   // Intake to table
   logic                  ins_req;
   logic [THR_W-1:0]      ins_thr;
   logic [DATA_WIDTH-1:0] ins_data0;
   logic [DATA_WIDTH-1:0] ins_data1;
   logic                  ins_gnt;
   logic                  ins_nack;

   mondo_intake #(.NUM_THREADS(NUM_THREADS)) mondo_intake_i (
      .clk, .reset,
      .mondo_valid, .mondo_ready, .mondo_thr, .mondo_data0, .mondo_data1,
      .ins_req, .ins_thr, .ins_data0, .ins_data1, .ins_gnt, .ins_nack,
      .ack_valid, .ack_nack
   );

   mondo_creg_access #(.NUM_THREADS(NUM_THREADS)) mondo_creg_access_i (
      .clk, .reset,
      .req_valid, .req_ready, .req_write, .req_addr, .req_thr, .req_wdata,
      .rsp_valid, .rsp_ready, .rsp_data, .rsp_err,
      .csr_wr_en, .csr_sel, .csr_idx, .csr_wdata,
      .csr_rd_idx, .rd_data0, .rd_data1, .rd_busy
   );

   mondo_data_table #(.NUM_THREADS(NUM_THREADS)) mondo_data_table_i (
      .clk, .reset,
      .csr_wr_en, .csr_sel, .csr_idx, .csr_wdata,
      .csr_rd_idx, .rd_data0, .rd_data1, .rd_busy,
      .ins_req, .ins_thr, .ins_data0, .ins_data1, .ins_gnt, .ins_nack
   );

endmodule

//--- bench/mondo_unit_tb.sv
`timescale 1ns/10ps

module mondo_unit_tb;

   localparam int NUM_THREADS = 32;
   localparam int THR_W = $clog2(NUM_THREADS);
   // Cycle limit of every wait loop
   localparam int TIMEOUT = 200;

   logic clk = 1'b0;
   logic reset;
   logic mondo_valid;
   logic mondo_ready;
   logic [THR_W-1:0] mondo_thr;
   logic [63:0] mondo_data0;
   logic [63:0] mondo_data1;
   logic ack_valid;
   logic ack_nack;
   logic req_valid;
   logic req_ready;
   logic req_write;
   logic [15:0] req_addr;
   logic [THR_W-1:0] req_thr;
   logic [63:0] req_wdata;
   logic rsp_valid;
   logic rsp_ready;
   logic [63:0] rsp_data;
   logic rsp_err;

   // Reference model of the table
   logic [63:0] m_data0 [NUM_THREADS];
   logic [63:0] m_data1 [NUM_THREADS];
   logic m_busy [NUM_THREADS];
   logic [31:0] lcg_state = 32'hcee68147;

   mondo_unit #(.NUM_THREADS(NUM_THREADS)) mondo_unit_i (
      .clk, .reset,
      .mondo_valid, .mondo_ready, .mondo_thr, .mondo_data0, .mondo_data1,
      .ack_valid, .ack_nack,
      .req_valid, .req_ready, .req_write, .req_addr, .req_thr, .req_wdata,
      .rsp_valid, .rsp_ready, .rsp_data, .rsp_err
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [63:0] rnd64();
      return {lcg_next(), lcg_next()};
   endfunction

   // Maps a select code and a thread to a register address
   // Select 0 is data0, 1 is data1 and 2 is busy
   function automatic logic [15:0] reg_addr(int sel, bit use_alias, logic [THR_W-1:0] thr);
      logic [15:0] base;
      case (sel)
         0: base = use_alias ? 16'h4000 : 16'h0000;
         1: base = use_alias ? 16'h4008 : 16'h1000;
         default: base = use_alias ? 16'h4010 : 16'h2000;
      endcase
      return use_alias ? base : base | (16'(thr) << 3);
   endfunction

   // Addresses outside both decodes
   function automatic logic [15:0] bad_addr(logic [2:0] k);
      case (k)
         3'd0: return 16'h3000;
         3'd1: return 16'h0004;
         3'd2: return 16'h4018;
         3'd3: return 16'h4001;
         3'd4: return 16'h8010;
         3'd5: return 16'h5000;
         3'd6: return 16'h2002;
         default: return 16'hf000;
      endcase
   endfunction

   function automatic logic [63:0] model_value(int sel, logic [THR_W-1:0] thr);
      case (sel)
         0: return m_data0[thr];
         1: return m_data1[thr];
         default: return {63'd0, m_busy[thr]};
      endcase
   endfunction

   task automatic end_with_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic compare_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
      assert (act === exp) else begin
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic enforce_timeout(input string what, input int cnt);
      assert (cnt < TIMEOUT) else begin
         $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
         end_with_failure();
      end
   endtask

   // One register transaction that starts and ends 1 ns after an edge
   task automatic reg_req(input string name, input logic wr, input logic [15:0] addr,
                          input logic [THR_W-1:0] thr, input logic [63:0] wdata,
                          output logic [63:0] rdata, output logic err);
      int cnt;
      req_valid = 1'b1;
      req_write = wr;
      req_addr = addr;
      req_thr = thr;
      req_wdata = wdata;
      cnt = 0;
      #1;
      while (!req_ready) begin
         cnt++;
         enforce_timeout({name, " request accept"}, cnt);
         @(posedge clk);
         #2;
      end
      // Accepted at this edge
      @(posedge clk);
      #1;
      req_valid = 1'b0;
      cnt = 0;
      while (!rsp_valid) begin
         cnt++;
         enforce_timeout({name, " response"}, cnt);
         @(posedge clk);
         #1;
      end
      // Response due one cycle after acceptance
      compare_value({name, " latency"}, 0, cnt);
      rdata = rsp_data;
      err = rsp_err;
   endtask

   task automatic creg_write(input string name, input int sel, input bit use_alias,
                             input logic [THR_W-1:0] thr, input logic [63:0] wdata);
      logic [63:0] rd;
      logic err;
      // Proper form gets a foreign req_thr that the decode must ignore
      reg_req(name, 1'b1, reg_addr(sel, use_alias, thr), use_alias ? thr : ~thr, wdata, rd, err);
      compare_value({name, " err"}, 0, err);
      compare_value({name, " data"}, 0, rd);
      case (sel)
         0: m_data0[thr] = wdata;
         1: m_data1[thr] = wdata;
         default: m_busy[thr] = wdata[0];
      endcase
   endtask

   task automatic creg_read(input string name, input int sel, input bit use_alias,
                            input logic [THR_W-1:0] thr);
      logic [63:0] rd;
      logic err;
      reg_req(name, 1'b0, reg_addr(sel, use_alias, thr), use_alias ? thr : ~thr, 64'd0, rd, err);
      compare_value({name, " err"}, 0, err);
      compare_value({name, " data"}, model_value(sel, thr), rd);
   endtask

   task automatic bad_access(input string name, input logic [15:0] addr, input logic wr,
                             input logic [63:0] wdata, input logic [THR_W-1:0] thr);
      logic [63:0] rd;
      logic err;
      reg_req(name, wr, addr, thr, wdata, rd, err);
      compare_value({name, " err"}, 1, err);
      compare_value({name, " data"}, 0, rd);
   endtask

   // Sends a mondo and waits for its ack
   // Nack predicted from the model busy flag
   task automatic send_mondo(input string name, input logic [THR_W-1:0] thr,
                             input logic [63:0] d0, input logic [63:0] d1);
      int cnt;
      logic exp_nack;
      exp_nack = m_busy[thr];
      mondo_valid = 1'b1;
      mondo_thr = thr;
      mondo_data0 = d0;
      mondo_data1 = d1;
      cnt = 0;
      #1;
      while (!mondo_ready) begin
         cnt++;
         enforce_timeout({name, " mondo accept"}, cnt);
         @(posedge clk);
         #2;
      end
      @(posedge clk);
      #1;
      mondo_valid = 1'b0;
      // Stage now holds the mondo and no grant has happened yet
      compare_value({name, " mondo_ready while held"}, 0, mondo_ready);
      compare_value({name, " early ack"}, 0, ack_valid);
      cnt = 0;
      while (!ack_valid) begin
         cnt++;
         enforce_timeout({name, " ack"}, cnt);
         @(posedge clk);
         #1;
      end
      compare_value({name, " nack"}, exp_nack, ack_nack);
      // Grant emptied the stage
      compare_value({name, " mondo_ready after ack"}, 1, mondo_ready);
      if (!exp_nack) begin
         m_data0[thr] = d0;
         m_data1[thr] = d1;
         m_busy[thr] = 1'b1;
      end
   endtask

   // Full sweep through proper addresses
   task automatic verify_all(input string name);
      for (int t = 0; t < NUM_THREADS; t++) begin
         for (int s = 0; s < 3; s++) begin
            creg_read(name, s, 1'b0, THR_W'(t));
         end
      end
   endtask

   // Data words start unknown and every entry gets loaded first
   task automatic init_table();
      for (int t = 0; t < NUM_THREADS; t++) begin
         creg_write("init mdata0", 0, 1'b0, THR_W'(t), rnd64());
         creg_write("init mdata1", 1, 1'b0, THR_W'(t), rnd64());
      end
   endtask

   task automatic alias_access();
      logic [THR_W-1:0] wr_thr [4] = '{3, 17, 30, 0};
      logic [THR_W-1:0] rd_thr [8] = '{3, 4, 17, 18, 30, 31, 0, 1};
      foreach (wr_thr[i]) begin
         creg_write("alias mdata0 write", 0, 1'b1, wr_thr[i], rnd64());
         creg_write("alias mdata1 write", 1, 1'b1, wr_thr[i], rnd64());
      end
      // Neighbours must still hold their old words
      foreach (rd_thr[i]) begin
         creg_read("alias mdata0 read", 0, 1'b1, rd_thr[i]);
         creg_read("alias mdata1 read", 1, 1'b1, rd_thr[i]);
      end
   endtask

   task automatic proper_alias_agreement();
      logic [THR_W-1:0] thr [3] = '{5, 12, 25};
      foreach (thr[i]) begin
         creg_write("proper mdata0 write", 0, 1'b0, thr[i], rnd64());
         creg_read("alias mdata0 view", 0, 1'b1, thr[i]);
         creg_write("alias mdata1 write", 1, 1'b1, thr[i], rnd64());
         creg_read("proper mdata1 view", 1, 1'b0, thr[i]);
         creg_write("proper busy set", 2, 1'b0, thr[i], 64'd1);
         creg_read("alias busy view", 2, 1'b1, thr[i]);
         creg_write("alias busy clear", 2, 1'b1, thr[i], 64'd0);
         creg_read("proper busy view", 2, 1'b0, thr[i]);
      end
      verify_all("proper sweep");
   endtask

   task automatic bad_address_errors();
      for (int k = 0; k < 8; k++) begin
         bad_access("bad address read", bad_addr(3'(k)), 1'b0, 64'd0, THR_W'(k));
         bad_access("bad address write", bad_addr(3'(k)), 1'b1, rnd64(), THR_W'(k));
      end
      verify_all("bad address sweep");
   endtask

   task automatic mondo_busy_flow();
      logic [THR_W-1:0] t;
      t = 9;
      creg_write("busy precheck clear", 2, 1'b1, t, 64'd0);
      send_mondo("first mondo", t, rnd64(), rnd64());
      for (int s = 0; s < 3; s++) begin
         creg_read("first mondo readback", s, 1'b1, t);
      end
      // Entry still busy and this one bounces
      send_mondo("second mondo", t, rnd64(), rnd64());
      for (int s = 0; s < 3; s++) begin
         creg_read("second mondo readback", s, 1'b1, t);
      end
      creg_write("software busy clear", 2, 1'b1, t, 64'd0);
      send_mondo("third mondo", t, rnd64(), rnd64());
      for (int s = 0; s < 3; s++) begin
         creg_read("third mondo readback", s, 1'b0, t);
      end
   endtask

   task automatic response_backpressure();
      logic [63:0] held;
      logic err;
      logic [63:0] bd0 [6];
      logic [63:0] bd1 [6];
      // Let the previous response drain first
      @(posedge clk);
      #1;
      rsp_ready = 1'b0;
      reg_req("held read", 1'b0, reg_addr(0, 1'b1, 4), 4, 64'd0, held, err);
      compare_value("held read data", m_data0[4], held);
      compare_value("held read err", 0, err);
      // Bad address waits behind the held response and must not get in
      req_valid = 1'b1;
      req_write = 1'b0;
      req_addr = 16'h3000;
      req_thr = 4;
      repeat (4) begin
         @(posedge clk);
         #2;
         compare_value("held rsp_valid", 1, rsp_valid);
         compare_value("held rsp_data", m_data0[4], rsp_data);
         compare_value("held rsp_err", 0, rsp_err);
         compare_value("held req_ready", 0, req_ready);
      end
      @(posedge clk);
      #1;
      req_valid = 1'b0;
      rsp_ready = 1'b1;
      @(posedge clk);
      #1;
      compare_value("drained rsp_valid", 0, rsp_valid);
      for (int i = 0; i < 6; i++) begin
         creg_write("burst busy clear", 2, 1'b0, THR_W'(8 + i), 64'd0);
         bd0[i] = rnd64();
         bd1[i] = rnd64();
      end
      // Mondos to 8..13 race register writes to 20..27
      fork
         for (int i = 0; i < 6; i++) begin
            send_mondo("burst mondo", THR_W'(8 + i), bd0[i], bd1[i]);
         end
         for (int i = 0; i < 8; i++) begin
            creg_write("burst write", i % 2, 1'b1, THR_W'(20 + i), 64'h0123_4567_0000_0000 | i);
         end
      join
      verify_all("burst sweep");
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      logic [THR_W-1:0] t;
      int sel;
      for (int i = 0; i < 80; i++) begin
         r = lcg_next();
         t = THR_W'(r >> 8);
         sel = (r >> 16) % 3;
         case (r[2:0])
            3'd0: send_mondo("random mondo", t, rnd64(), rnd64());
            3'd1, 3'd2: creg_write("random write", sel, r[20], t, rnd64());
            3'd3, 3'd4, 3'd5: creg_read("random read", sel, r[20], t);
            3'd6: bad_access("random bad address", bad_addr(r[26:24]), r[27], rnd64(), t);
            default: creg_write("random busy clear", 2, r[20], t, 64'd0);
         endcase
      end
      verify_all("random sweep");
   endtask

   initial begin
      reset = 1'b1;
      mondo_valid = 1'b0;
      mondo_thr = '0;
      mondo_data0 = '0;
      mondo_data1 = '0;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_addr = '0;
      req_thr = '0;
      req_wdata = '0;
      rsp_ready = 1'b1;
      // Busy flags come out of reset clear
      for (int t = 0; t < NUM_THREADS; t++) begin
         m_busy[t] = 1'b0;
      end
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      init_table();
      alias_access();
      proper_alias_agreement();
      bad_address_errors();
      mondo_busy_flow();
      response_backpressure();
      random_traffic();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- verilog.f
logic/mondo_pkg.sv
logic/mondo_addr_dec.sv
logic/mondo_data_table.sv
logic/mondo_intake.sv
logic/mondo_creg_access.sv
logic/mondo_unit.sv
bench/mondo_unit_tb.sv

//--- Bender.yml
package:
  name: mondo_unit

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - logic/mondo_pkg.sv
      - logic/mondo_addr_dec.sv
      - logic/mondo_data_table.sv
      - logic/mondo_intake.sv
      - logic/mondo_creg_access.sv
      - logic/mondo_unit.sv

  # Testbench, top module mondo_unit_tb
  - target: test
    files:
      - bench/mondo_unit_tb.sv
